/* obj_defines.svh */
// widths and constants for the sprite line stage
// include this in any file that needs the sizes, the guard keeps repeats harmless
`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// line buffer address width, one half holds 512 pixels
`define OBJ_AW 9

// colour index and palette widths
`define OBJ_CW 4
`define OBJ_PW 4

// command queue entries, also the credits the host starts with
`define OBJ_FIFO_DEPTH 4

// added to the inverted x when the screen is flipped
`define OBJ_FLIP_OFFSET 8

// clocks from rd sampled high to pix valid
`define OBJ_RD_DLY 2

`endif

/* obj_pkg.sv */
// shared types for the sprite line stage
// modules import this for commands, pixels, write beats and the drawer FSM
`include "obj_defines.svh"

package obj_pkg;

    // one sprite row as sent by the host
    typedef struct packed {
        logic [`OBJ_AW-1:0]   xpos;    // x of the first pixel
        logic [`OBJ_PW-1:0]   pal;
        logic                 hflip;
        logic [8*`OBJ_CW-1:0] pixels;  // pixel 0 sits in the low nibble
    } obj_cmd_t;

    // line buffer word, color 0 is transparent or blank
    typedef struct packed {
        logic [`OBJ_PW-1:0] pal;
        logic [`OBJ_CW-1:0] color;
    } obj_pix_t;

    // one pixel write from the drawer
    typedef struct packed {
        logic [`OBJ_AW-1:0] addr;
        obj_pix_t           pix;
        logic               we;
    } obj_wr_t;

    typedef enum logic {
        DRAW_IDLE,
        DRAW_RUN
    } draw_state_e;

endpackage

/* obj_dual_ram.sv */
// true dual-port RAM holding both halves of the sprite line
// single clock, registered reads, a read during a write returns the old word
`timescale 1ns/1ns
`include "obj_defines.svh"

module obj_dual_ram (
    input  logic                 clk,
    // port 0
    input  logic [`OBJ_AW:0]     a0,
    input  obj_pkg::obj_pix_t    d0,
    input  logic                 we0,
    output obj_pkg::obj_pix_t    q0,
    // port 1
    input  logic [`OBJ_AW:0]     a1,
    input  obj_pkg::obj_pix_t    d1,
    input  logic                 we1,
    output obj_pkg::obj_pix_t    q1
);
    localparam int WORDS = 2 ** (`OBJ_AW + 1);

    obj_pkg::obj_pix_t mem [WORDS];

    // start with both halves blank
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // both ports in one process so the array has a single writer
    // nonblocking reads see the word from before this edge's writes
    always @(posedge clk) begin
        q0 <= mem[a0];
        q1 <= mem[a1];
        if (we0) begin
            mem[a0] <= d0;
        end
        if (we1) begin
            mem[a1] <= d1;
        end
    end

endmodule

/* obj_cmd_fifo.sv */
// command queue between the host and the drawer
// host pushes under credit control, every pop returns one credit a clock later
`timescale 1ns/1ns
`include "obj_defines.svh"

module obj_cmd_fifo (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  obj_pkg::obj_cmd_t push_cmd,
    input  logic              pop,
    output obj_pkg::obj_cmd_t head,
    output logic              not_empty,
    output logic              credit
);
    import obj_pkg::*;

    localparam int DEPTH = `OBJ_FIFO_DEPTH;
    localparam int PTRW  = $clog2(DEPTH);
    localparam int CNTW  = $clog2(DEPTH + 1);

    obj_cmd_t        mem [DEPTH];
    logic [PTRW-1:0] wr_ptr;
    logic [PTRW-1:0] rd_ptr;
    logic [CNTW-1:0] count;
    logic            full;
    logic            do_push;
    logic            do_pop;

    assign full      = count == CNTW'(DEPTH);
    assign not_empty = count != '0;
    // a push into a full queue breaks the credit contract, drop it
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;

    // head is the oldest entry, read combinationally
    assign head = mem[rd_ptr];

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy only moves when exactly one side acts
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // registered pop is the credit pulse
            credit <= do_pop;
        end
    end

endmodule

/* obj_draw.sv */
// sprite row drawer, turns one command into eight pixel writes
// handles horizontal flip and marks transparent pixels with we low
// the next command is taken on the eighth pixel so rows stream back to back
`timescale 1ns/1ns
`include "obj_defines.svh"

module obj_draw (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::obj_cmd_t cmd,
    input  logic              cmd_avail,
    output logic              pop,
    output obj_pkg::obj_wr_t  wr,
    output logic              draw_idle
);
    import obj_pkg::*;

    localparam int AW = `OBJ_AW;
    localparam int CW = `OBJ_CW;

    draw_state_e   state;
    obj_cmd_t      work;     // command being drawn
    logic [2:0]    idx;      // pixel counter within the row
    logic          last;
    logic [2:0]    sel;      // pixel picked from the row
    logic [CW-1:0] color;
    logic [AW-1:0] addr;

    // registered write beat
    logic [AW-1:0] wr_addr;
    obj_pix_t      wr_pix;
    logic          wr_we;

    assign last = idx == 3'd7;

    // take a command when idle or when finishing the current row
    assign pop = cmd_avail && (state == DRAW_IDLE || (state == DRAW_RUN && last));

    // flipped rows read pixels 7 down to 0, which is the bitwise inverse of idx
    assign sel   = work.hflip ? ~idx : idx;
    assign color = work.pixels[sel*CW +: CW];
    // x wraps modulo the line length
    assign addr  = work.xpos + AW'(idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DRAW_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    idx <= '0;
                    if (cmd_avail) begin
                        state <= DRAW_RUN;
                    end
                end
                DRAW_RUN: begin
                    // wraps to 0 after pixel 7, ready for a streamed row
                    idx <= idx + 1'b1;
                    if (last && !cmd_avail) begin
                        state <= DRAW_IDLE;
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    // working copy of the popped command
    always_ff @(posedge clk) begin
        if (pop) begin
            work <= cmd;
        end
    end

    // write enable is control, address and pixel are payload
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_we <= 1'b0;
        end else begin
            // colour 0 never reaches the buffer
            wr_we <= state == DRAW_RUN && color != '0;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= addr;
        wr_pix  <= '{pal: work.pal, color: color};
    end

    assign wr = '{addr: wr_addr, pix: wr_pix, we: wr_we};

    // nothing in flight and nothing waiting
    assign draw_idle = state == DRAW_IDLE && !cmd_avail;

endmodule

/* obj_line_buffer.sv */
// ping-pong sprite line buffer
// the drawer writes one half while video reads the other, halves swap when lhbl falls
// reads erase what they return so each half comes back blank for the next line
// flip mirrors write addresses to the inverted x plus a fixed offset
`timescale 1ns/1ns
`include "obj_defines.svh"

module obj_line_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lhbl,
    input  logic                 flip,
    input  obj_pkg::obj_wr_t     wr,
    input  logic [`OBJ_AW-1:0]   rd_addr,
    input  logic                 rd,
    output obj_pkg::obj_pix_t    pix
);
    import obj_pkg::*;

    localparam int              AW       = `OBJ_AW;
    localparam int              DLY      = `OBJ_RD_DLY;
    localparam logic [AW-1:0]   FLIP_OFF = AW'(`OBJ_FLIP_OFFSET);
    localparam logic [DLY-1:0]  DLY_TOP  = DLY'(1) << (DLY - 1);

    logic           line;       // half being written
    logic           last_lhbl;
    logic [DLY-1:0] dly;        // read timing, one bit walks down to bit 0
    logic           erase;
    logic           opaque;
    logic [AW-1:0]  wr_af;      // write address after flip
    obj_pix_t       rd_q;

    // swap halves on the falling edge of lhbl
    always_ff @(posedge clk) begin
        if (rst) begin
            line      <= 1'b0;
            last_lhbl <= 1'b0;
        end else begin
            last_lhbl <= lhbl;
            if (!lhbl && last_lhbl) begin
                line <= ~line;
            end
        end
    end

    // second guard on transparency, only opaque beats are written
    assign opaque = wr.we && wr.pix.color != '0;

    // mirrored x under screen flip
    assign wr_af = flip ? ~wr.addr + FLIP_OFF : wr.addr;

    // rd loads the top bit, the ram output is ready when it reaches bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            dly <= '0;
        end else if (rd) begin
            dly <= DLY_TOP;
        end else begin
            dly <= dly >> 1;
        end
    end

    assign erase = dly[0];

    // capture the stored pixel on the same edge the location is blanked
    always_ff @(posedge clk) begin
        if (rst) begin
            pix <= '0;
        end else if (erase) begin
            pix <= rd_q;
        end
    end

    // port 0 draws into the active half, port 1 reads and erases the other one
    obj_dual_ram u_ram (
        .clk ( clk              ),
        .a0  ( {line, wr_af}    ),
        .d0  ( wr.pix           ),
        .we0 ( opaque           ),
        .q0  (                  ),
        .a1  ( {~line, rd_addr} ),
        .d1  ( '0               ),
        .we1 ( erase            ),
        .q1  ( rd_q             )
    );

endmodule

/* obj_line_top.sv */
// sprite line stage top level
// host commands go through the credit queue to the drawer, which fills the line buffer
// video reads pixels back with a fixed latency
`timescale 1ns/1ns
`include "obj_defines.svh"

module obj_line_top (
    input  logic                 clk,
    input  logic                 rst,
    // command input, credit flow
    input  logic                 cmd_valid,
    input  obj_pkg::obj_cmd_t    cmd,
    output logic                 cmd_credit,
    output logic                 draw_idle,
    // video side
    input  logic                 lhbl,
    input  logic                 flip,
    input  logic [`OBJ_AW-1:0]   rd_addr,
    input  logic                 rd,
    output obj_pkg::obj_pix_t    pix
);
    import obj_pkg::*;

    obj_cmd_t fifo_head;
    logic     fifo_not_empty;
    logic     draw_pop;
    obj_wr_t  draw_wr;

    // queue, one credit back per pop
    obj_cmd_fifo u_fifo (
        .clk       ( clk            ),
        .rst       ( rst            ),
        .push      ( cmd_valid      ),
        .push_cmd  ( cmd            ),
        .pop       ( draw_pop       ),
        .head      ( fifo_head      ),
        .not_empty ( fifo_not_empty ),
        .credit    ( cmd_credit     )
    );

    // row expander
    obj_draw u_draw (
        .clk       ( clk            ),
        .rst       ( rst            ),
        .cmd       ( fifo_head      ),
        .cmd_avail ( fifo_not_empty ),
        .pop       ( draw_pop       ),
        .wr        ( draw_wr        ),
        .draw_idle ( draw_idle      )
    );

    // ping-pong buffer
    obj_line_buffer u_lbuf (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .lhbl    ( lhbl    ),
        .flip    ( flip    ),
        .wr      ( draw_wr ),
        .rd_addr ( rd_addr ),
        .rd      ( rd      ),
        .pix     ( pix     )
    );

endmodule

/* obj_line_props.sv */
// assertions for the sprite line stage, bound onto the top level
// covers the credit contract, the write beat and the idle flag
`timescale 1ns/1ns
`include "obj_defines.svh"

module obj_line_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 cmd_valid,
    input logic                 cmd_credit,
    input logic                 draw_pop,
    input logic                 draw_idle,
    input obj_pkg::obj_wr_t     draw_wr,
    input obj_pkg::draw_state_e draw_state
);
    import obj_pkg::*;

    localparam int DEPTH = `OBJ_FIFO_DEPTH;
    localparam int CNTW  = $clog2(DEPTH + 1);

    logic [CNTW-1:0] occ;
    logic            full;

    assign full = occ == CNTW'(DEPTH);

    // own count of queue entries
    always_ff @(posedge clk) begin
        if (rst) begin
            occ <= '0;
        end else begin
            case ({cmd_valid && !full, draw_pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    no_push_full: assert property (@(posedge clk) disable iff (rst) cmd_valid |-> !full)
        else $error("push into a full command queue");

    // one credit pulse per pop, exactly one clock later
    credit_pairs: assert property (@(posedge clk) disable iff (rst)
        cmd_credit == $past(draw_pop))
        else $error("credit pulse does not match the pop one clock earlier");

    no_clear_write: assert property (@(posedge clk) disable iff (rst)
        draw_wr.we |-> draw_wr.pix.color != '0)
        else $error("write enable with colour 0");

    // idle means the FSM rests and the counted queue is empty
    idle_flag: assert property (@(posedge clk) disable iff (rst)
        draw_idle == (draw_state == DRAW_IDLE && occ == '0))
        else $error("draw_idle does not match an idle drawer with an empty queue");

endmodule

bind obj_line_top obj_line_props u_props (
    .clk            ( clk            ),
    .rst            ( rst            ),
    .cmd_valid      ( cmd_valid      ),
    .cmd_credit     ( cmd_credit     ),
    .draw_pop       ( draw_pop       ),
    .draw_idle      ( draw_idle      ),
    .draw_wr        ( draw_wr        ),
    .draw_state     ( u_draw.state   )
);

/* tb_obj_line.sv */
// directed testbench for the sprite line stage
// keeps a model of both line halves and compares every video read against it
`timescale 1ns/1ns
`include "obj_defines.svh"

module tb_obj_line;
    import obj_pkg::*;

    localparam int AW        = `OBJ_AW;
    localparam int LINE      = 2 ** AW;
    localparam int DEPTH     = `OBJ_FIFO_DEPTH;
    localparam int RST_CYC   = 16;
    localparam int N_TESTS   = 5;
    localparam int TEST_CYC  = 200;
    // one full line sweep at three clocks per read
    localparam int SWEEP_CYC = LINE * 3;
    localparam int WDOG_NS   = (RST_CYC + N_TESTS * TEST_CYC + SWEEP_CYC) * 8;

    logic          clk;
    logic          rst;
    logic          cmd_valid;
    obj_cmd_t      cmd;
    logic          cmd_credit;
    logic          draw_idle;
    logic          lhbl;
    logic          flip;
    logic [AW-1:0] rd_addr;
    logic          rd;
    obj_pix_t      pix;

    // model halves, indexed by {half, x}
    obj_pix_t ref_mem [2*LINE];
    logic     ref_line;
    int       sent = 0;
    int       returned = 0;
    integer   seed;

    obj_line_top i_obj_line_top (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cmd_valid  ( cmd_valid  ),
        .cmd        ( cmd        ),
        .cmd_credit ( cmd_credit ),
        .draw_idle  ( draw_idle  ),
        .lhbl       ( lhbl       ),
        .flip       ( flip       ),
        .rd_addr    ( rd_addr    ),
        .rd         ( rd         ),
        .pix        ( pix        )
    );

    always #4 clk = ~clk;

    // credit pulses, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && cmd_credit) begin
            returned = returned + 1;
        end
    end

    initial begin
        #(WDOG_NS);
        report_fail("watchdog timeout, the tests did not finish in time");
    end

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
                                  name, got, exp));
        end
    endtask

    // random row, every colour forced opaque
    function automatic logic [31:0] opaque_row();
        logic [31:0] r;
        r = $random(seed);
        for (int i = 0; i < 8; i++) begin
            if (r[i*4 +: 4] == 4'h0) begin
                r[i*4 +: 4] = 4'h1;
            end
        end
        return r;
    endfunction

    // apply one row to the half being drawn
    task automatic model_draw(input obj_cmd_t c, input logic fl);
        logic [AW-1:0] a;
        logic [2:0]    s;
        logic [3:0]    col;
        for (int i = 0; i < 8; i++) begin
            s   = c.hflip ? 3'(7 - i) : 3'(i);
            col = c.pixels[s*4 +: 4];
            a   = c.xpos + AW'(i);
            // mirrored x counts back from the right end, then the fixed offset
            if (fl) begin
                a = AW'((LINE - 1) - int'(a) + `OBJ_FLIP_OFFSET);
            end
            if (col != 4'h0) begin
                ref_mem[{ref_line, a}] = '{pal: c.pal, color: col};
            end
        end
    endtask

    // reads erase, so the model clears what it hands out
    task automatic model_take(input logic [AW-1:0] a, output obj_pix_t p);
        p = ref_mem[{~ref_line, a}];
        ref_mem[{~ref_line, a}] = '0;
    endtask

    task automatic send_sprite(input logic [AW-1:0] x, input logic [3:0] p,
                               input logic hf, input logic [31:0] px);
        obj_cmd_t c;
        c = '{xpos: x, pal: p, hflip: hf, pixels: px};
        // no credit left, wait for one to come back
        while (sent - returned >= DEPTH) begin
            @(posedge clk);
            #1;
        end
        model_draw(c, flip);
        cmd_valid = 1'b1;
        cmd = c;
        sent++;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!draw_idle) begin
            n++;
            if (n > 100) begin
                report_fail("drawer never returned to idle");
            end
            @(negedge clk);
        end
        // last beat still sits in the write register, then the ram
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic swap_line();
        lhbl = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        lhbl = 1'b1;
        ref_line = ~ref_line;
        @(posedge clk);
        #1;
    endtask

    task automatic read_pix(input logic [AW-1:0] a, output obj_pix_t p);
        rd = 1'b1;
        rd_addr = a;
        @(posedge clk);
        #1;
        rd = 1'b0;
        // address held through the capture and erase edge
        repeat (2) @(posedge clk);
        #1;
        p = pix;
    endtask

    task automatic check_read(input logic [AW-1:0] a);
        obj_pix_t got;
        obj_pix_t exp;
        read_pix(a, got);
        model_take(a, exp);
        check_val($sformatf("pix[%0d]", a), 32'(got), 32'(exp));
    endtask

    task automatic check_range(input logic [AW-1:0] lo, input int n);
        for (int j = 0; j < n; j++) begin
            check_read(lo + AW'(j));
        end
    endtask

    task automatic test_single_sprite();
        check_val("cmd_credit", 32'(cmd_credit), 32'h0);
        check_val("draw_idle", 32'(draw_idle), 32'h1);
        check_val("pix", 32'(pix), 32'h0);
        send_sprite(9'd40, 4'h9, 1'b0, opaque_row());
        wait_idle();
        swap_line();
        // whole line, only the eight sprite pixels are set
        check_range(9'd0, LINE);
    endtask

    task automatic test_overlap();
        logic [31:0] row_b;
        // holes at nibbles 1 and 5, x 110 and x 106 once flipped
        row_b = opaque_row() & 32'hFF0F_FF0F;
        send_sprite(9'd100, 4'h3, 1'b0, opaque_row());
        send_sprite(9'd104, 4'h5, 1'b1, row_b);
        // runs off the right end and wraps to x 0
        send_sprite(9'd508, 4'hc, 1'b0, opaque_row());
        wait_idle();
        swap_line();
        check_range(9'd98, 16);
        check_range(9'd505, 12);
    endtask

    task automatic test_erase();
        obj_pix_t got;
        send_sprite(9'd200, 4'h7, 1'b0, opaque_row());
        wait_idle();
        swap_line();
        for (int i = 0; i < 8; i++) begin
            check_read(9'd200 + 9'(i));
            // same line, second read finds it blank
            read_pix(9'd200 + 9'(i), got);
            check_val("pix after erase", 32'(got), 32'h0);
        end
    endtask

    task automatic test_flip();
        flip = 1'b1;
        send_sprite(9'd2, 4'ha, 1'b0, opaque_row());
        send_sprite(9'd60, 4'h6, 1'b1, opaque_row());
        wait_idle();
        flip = 1'b0;
        swap_line();
        // x 2..9 lands on 5 down to 510, x 60..67 on 459 down to 452
        check_range(9'd506, 12);
        check_range(9'd450, 12);
    endtask

    task automatic test_credits();
        int base;
        base = returned;
        check_val("credits at start", 32'(DEPTH - (sent - returned)), 32'(DEPTH));
        // six rows, the queue fills and the last row waits for a credit
        for (int j = 0; j < 6; j++) begin
            send_sprite(9'd300 + 9'(8 * j), 4'(j + 1), 1'b0, opaque_row());
        end
        wait_idle();
        check_val("credits returned", 32'(returned - base), 32'd6);
        check_val("credits outstanding", 32'(sent - returned), 32'd0);
        swap_line();
        check_range(9'd300, 48);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        lhbl      = 1'b1;
        flip      = 1'b0;
        rd_addr   = '0;
        rd        = 1'b0;
        ref_line  = 1'b0;
        seed      = 32'habba;
        for (int i = 0; i < 2 * LINE; i++) begin
            ref_mem[i] = '0;
        end
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
        test_single_sprite();
        test_overlap();
        test_erase();
        test_flip();
        test_credits();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
obj_pkg.sv
obj_dual_ram.sv
obj_cmd_fifo.sv
obj_draw.sv
obj_line_buffer.sv
obj_line_top.sv
obj_line_props.sv
tb_obj_line.sv

/* run.sh */
#!/bin/sh
# build and run the sprite line stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_obj_line \
    -Mdir obj_dir -o sim_obj_line
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_obj_line > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
